// ==== source/lspcPkg.sv ====
// Shared widths, register word selects, LSPCMODE field positions and the write sequencer states
`default_nettype none

package lspcPkg;

	// ========================================
	// Data widths
	// ========================================
	typedef logic [15:0] cpuDataT;
	typedef logic [15:0] vramAddrT;
	// Word select from CPU address bits 3..1
	typedef logic [2:0]  regSelT;
	// Frames per animation step minus one
	typedef logic [7:0]  aaSpeedT;
	typedef logic [2:0]  aaCountT;
	typedef logic [19:0] sprTileT;

	// CPU VRAM write sequencer
	typedef enum logic [1:0] {
		idle     = 2'd0,
		waitSlot = 2'd1,
		bumpAddr = 2'd2
	} vramStateT;

	// ========================================
	// Register map ($3C0000 and up)
	// ========================================
	localparam regSelT REG_VRAMADDR = 3'd0;
	localparam regSelT REG_VRAMRW   = 3'd1;
	localparam regSelT REG_VRAMMOD  = 3'd2;
	localparam regSelT REG_LSPCMODE = 3'd3;

	// LSPCMODE bit fields
	localparam int MODE_AA_DISABLE  = 3;
	localparam int MODE_AA_SPEED_LO = 8;
	localparam int MODE_AA_SPEED_HI = 15;

	// Master divider width, 4 bits gives 3M and 1.5M
	localparam int DIV_STAGES_DEF = 4;

endpackage

`default_nettype wire

// ==== source/lspcClockDivider.sv ====
// Master clock divider with the CPU slot pulse and the 3 MHz and 1.5 MHz levels
`timescale 1ns/10ps
`default_nettype none

module lspcClockDivider #(
	parameter int DIV_STAGES = lspcPkg::DIV_STAGES_DEF
) (
	input  wire  CLK_24M,
	input  wire  T73A_OUT,
	output logic cpuSlot,
	output logic lspc3M,
	output logic lspc1_5M
);

	// Free-running master count
	logic [DIV_STAGES-1:0] divCnt;

	// ========================================
	// Divider chain
	// ========================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			divCnt <= '0;
		end
		else
		begin
			// Wraps naturally at the top
			divCnt <= divCnt + {{(DIV_STAGES-1){1'b0}}, 1'b1};
		end
	end

	// Bit 2 toggles every 4 clocks
	// 24M / 8 gives 3M
	assign lspc3M   = divCnt[2];
	// Half of that again
	assign lspc1_5M = divCnt[3];

	// CPU access phase
	// One clock out of every four
	// Last quarter of each 3M half period
	assign cpuSlot = &divCnt[1:0];

endmodule

`default_nettype wire

// ==== source/lspcCpuRegs.sv ====
// CPU register write decode, VRAMMOD and LSPCMODE registers, and registered read data
`timescale 1ns/10ps
`default_nettype none

module lspcCpuRegs (
	input  wire                CLK_24M,
	input  wire                T73A_OUT,
	input  wire lspcPkg::regSelT  cpuAddr,
	input  wire lspcPkg::cpuDataT cpuDataIn,
	input  wire                cpuWe,
	input  wire                cpuRe,
	input  wire lspcPkg::vramAddrT vramAddr,
	input  wire lspcPkg::cpuDataT vramRdData,
	input  wire lspcPkg::aaCountT aaCount,
	output lspcPkg::cpuDataT   cpuDataOut,
	output logic               addrWrite,
	output logic               dataWrite,
	output lspcPkg::cpuDataT   wrData,
	output lspcPkg::cpuDataT   vramMod,
	output lspcPkg::aaSpeedT   aaSpeed,
	output logic               aaDisable
);

	import lspcPkg::*;

	// LSPCMODE as seen by a read
	cpuDataT modeRd;

	// ========================================
	// Write decode
	// ========================================
	// Strobes to the address unit
	// Same cycle as the CPU strobe
	assign addrWrite = cpuWe && (cpuAddr == REG_VRAMADDR);
	assign dataWrite = cpuWe && (cpuAddr == REG_VRAMRW);
	// Write bus shared by both strobes
	assign wrData = cpuDataIn;

	// Modulo and mode registers
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			vramMod   <= '0;
			aaSpeed   <= '0;
			aaDisable <= 1'b0;
		end
		else if (cpuWe)
		begin
			if (cpuAddr == REG_VRAMMOD)
				vramMod <= cpuDataIn;
			if (cpuAddr == REG_LSPCMODE)
			begin
				aaSpeed   <= cpuDataIn[MODE_AA_SPEED_HI:MODE_AA_SPEED_LO];
				aaDisable <= cpuDataIn[MODE_AA_DISABLE];
			end
		end
	end

	// ========================================
	// Read side
	// ========================================
	// Speed in the high byte, flag and animation step low
	// No raster line here
	always_comb
	begin
		modeRd = '0;
		modeRd[MODE_AA_SPEED_HI:MODE_AA_SPEED_LO] = aaSpeed;
		modeRd[MODE_AA_DISABLE] = aaDisable;
		modeRd[2:0] = aaCount;
	end

	// Read data latched on the strobe and held until the next read
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			cpuDataOut <= '0;
		end
		else if (cpuRe)
		begin
			case (cpuAddr)
				REG_VRAMADDR: cpuDataOut <= vramAddr;
				// Word at the current address from the VRAM
				REG_VRAMRW:   cpuDataOut <= vramRdData;
				REG_VRAMMOD:  cpuDataOut <= vramMod;
				REG_LSPCMODE: cpuDataOut <= modeRd;
				// Unmapped words read as zero
				default:      cpuDataOut <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/vramAddressUnit.sv ====
// VRAM address register with modulo auto-increment and the CPU slot write sequencer
`timescale 1ns/10ps
`default_nettype none

module vramAddressUnit (
	input  wire                CLK_24M,
	input  wire                T73A_OUT,
	input  wire                addrWrite,
	input  wire                dataWrite,
	input  wire lspcPkg::cpuDataT wrData,
	input  wire lspcPkg::cpuDataT vramMod,
	input  wire                cpuSlot,
	output lspcPkg::vramAddrT  vramAddr,
	output lspcPkg::cpuDataT   vramWrData,
	output logic               vramWe
);

	import lspcPkg::*;

	vramStateT state;

	// ========================================
	// Write sequencer
	// ========================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			state    <= idle;
			vramAddr <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (dataWrite)
						state <= waitSlot;
				// Hold until the CPU access phase comes round
				waitSlot:
					if (cpuSlot)
						state <= bumpAddr;
				// Write cycle itself
				// A new request here queues straight away
				bumpAddr:
					state <= dataWrite ? waitSlot : idle;
				default:
					state <= idle;
			endcase

			// Direct load wins over the increment
			if (addrWrite)
				vramAddr <= wrData;
			else if (state == bumpAddr)
				vramAddr <= vramAddr + vramMod;
		end
	end

	// Pending data
	// A later write simply overwrites it
	always_ff @(posedge CLK_24M)
	begin
		if (dataWrite)
			vramWrData <= wrData;
	end

	// One pulse with the old address still on the bus
	assign vramWe = (state == bumpAddr);

endmodule

`default_nettype wire

// ==== source/autoAnimator.sv ====
// Auto-animation frame pacing, animation step counter and sprite tile bit substitution
`timescale 1ns/10ps
`default_nettype none

module autoAnimator (
	input  wire                CLK_24M,
	input  wire                T73A_OUT,
	input  wire                frameStrobe,
	input  wire lspcPkg::aaSpeedT aaSpeed,
	input  wire                aaDisable,
	input  wire lspcPkg::sprTileT sprTile,
	input  wire                sprAa2,
	input  wire                sprAa3,
	output lspcPkg::aaCountT   aaCount,
	output lspcPkg::sprTileT   sprTileAnim
);

	import lspcPkg::*;

	// Frames left before the next step
	aaSpeedT speedCnt;
	logic    aa3En;
	logic    aa2En;

	// ========================================
	// Frame pacing
	// ========================================
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			speedCnt <= '0;
			aaCount  <= '0;
		end
		else if (frameStrobe)
		begin
			// Runs even with the disable bit set
			if (speedCnt == '0)
			begin
				speedCnt <= aaSpeed;
				aaCount  <= aaCount + 3'd1;
			end
			else
			begin
				speedCnt <= speedCnt - 8'd1;
			end
		end
	end

	// ========================================
	// Tile substitution
	// ========================================
	// 8-frame loop takes priority over 4-frame loop
	assign aa3En = sprAa3 && !aaDisable;
	assign aa2En = aa3En || (sprAa2 && !aaDisable);

	assign sprTileAnim[19:3] = sprTile[19:3];
	assign sprTileAnim[2]    = aa3En ? aaCount[2] : sprTile[2];
	assign sprTileAnim[1:0]  = aa2En ? aaCount[1:0] : sprTile[1:0];

endmodule

`default_nettype wire

// ==== source/lspcCore.sv ====
// Top level of the CPU side tying divider, registers, VRAM address unit and animator together
`timescale 1ns/10ps
`default_nettype none

module lspcCore #(
	parameter int DIV_STAGES = lspcPkg::DIV_STAGES_DEF
) (
	input  wire                   CLK_24M,
	input  wire                   T73A_OUT,
	// CPU side
	input  wire lspcPkg::regSelT  cpuAddr,
	input  wire lspcPkg::cpuDataT cpuDataIn,
	output lspcPkg::cpuDataT      cpuDataOut,
	input  wire                   cpuWe,
	input  wire                   cpuRe,
	// VRAM side
	output lspcPkg::vramAddrT     vramAddr,
	output lspcPkg::cpuDataT      vramWrData,
	output logic                  vramWe,
	input  wire lspcPkg::cpuDataT vramRdData,
	// Frame and sprite side
	input  wire                   frameStrobe,
	input  wire lspcPkg::sprTileT sprTile,
	input  wire                   sprAa2,
	input  wire                   sprAa3,
	output lspcPkg::sprTileT      sprTileAnim,
	output logic                  s1h1,
	output logic                  s2h1,
	output lspcPkg::aaCountT      aaCount
);

	import lspcPkg::*;

	// ========================================
	// Internal nets
	// ========================================
	logic    cpuSlot;
	logic    addrWrite;
	logic    dataWrite;
	cpuDataT wrData;
	cpuDataT vramMod;
	aaSpeedT aaSpeed;
	logic    aaDisable;

	// Slot phase and the slow clock levels
	lspcClockDivider #(
		.DIV_STAGES(DIV_STAGES)
	) u_lspcClockDivider (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.cpuSlot(cpuSlot), .lspc3M(s1h1), .lspc1_5M(s2h1)
	);

	lspcCpuRegs u_lspcCpuRegs (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.cpuAddr(cpuAddr), .cpuDataIn(cpuDataIn), .cpuWe(cpuWe), .cpuRe(cpuRe),
		.vramAddr(vramAddr), .vramRdData(vramRdData), .aaCount(aaCount),
		.cpuDataOut(cpuDataOut), .addrWrite(addrWrite), .dataWrite(dataWrite),
		.wrData(wrData), .vramMod(vramMod), .aaSpeed(aaSpeed), .aaDisable(aaDisable)
	);

	vramAddressUnit u_vramAddressUnit (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.addrWrite(addrWrite), .dataWrite(dataWrite), .wrData(wrData),
		.vramMod(vramMod), .cpuSlot(cpuSlot),
		.vramAddr(vramAddr), .vramWrData(vramWrData), .vramWe(vramWe)
	);

	// Count also read back through LSPCMODE
	autoAnimator u_autoAnimator (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.frameStrobe(frameStrobe), .aaSpeed(aaSpeed), .aaDisable(aaDisable),
		.sprTile(sprTile), .sprAa2(sprAa2), .sprAa3(sprAa3),
		.aaCount(aaCount), .sprTileAnim(sprTileAnim)
	);

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
// Testbench clock source and power-on reset pulse
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic CLK_24M,
	output logic T73A_OUT
);

	// Free-running clock
	initial
	begin
		CLK_24M = 1'b0;
		forever #(PERIOD_NS / 2) CLK_24M = ~CLK_24M;
	end

	// Reset low for the first cycles
	// Released on a falling edge, away from the sampling edge
	initial
	begin
		T73A_OUT = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_24M);
		@(negedge CLK_24M);
		T73A_OUT = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/tbLspcCore.sv ====
// Table-driven testbench for the LSPC CPU side with a VRAM model, checks and a timeout
`timescale 1ns/10ps
`default_nettype none

module tbLspcCore;

	import lspcPkg::*;

	// Row operations
	localparam int OP_WRITE      = 0;
	localparam int OP_READ       = 1;
	localparam int OP_VRAM_WRITE = 2;
	localparam int OP_VRAM_READ  = 3;
	localparam int OP_FRAMES     = 4;
	localparam int OP_TILE       = 5;
	localparam int OP_IDLE       = 6;

	logic     CLK_24M;
	logic     T73A_OUT;
	regSelT   cpuAddr;
	cpuDataT  cpuDataIn;
	cpuDataT  cpuDataOut;
	logic     cpuWe;
	logic     cpuRe;
	vramAddrT vramAddr;
	cpuDataT  vramWrData;
	logic     vramWe;
	cpuDataT  vramRdData;
	logic     frameStrobe;
	sprTileT  sprTile;
	logic     sprAa2;
	logic     sprAa3;
	sprTileT  sprTileAnim;
	logic     s1h1;
	logic     s2h1;
	aaCountT  aaCount;

	// ========================================
	// Stimulus table and bookkeeping
	// ========================================
	int          opTab[$];
	logic [2:0]  selTab[$];
	logic [19:0] dataTab[$];
	logic [19:0] expTab[$];

	cpuDataT     vramMem [64];
	logic [31:0] rngState;
	int          errCount = 0;
	int          strayWeCount = 0;
	int          levelErrCount = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;
	logic        weExpected;
	// What the CPU side should hold
	vramAddrT    shadowAddr;
	cpuDataT     shadowMod;
	aaSpeedT     shadowSpeed;
	logic        shadowDis;
	// Clocks since reset release
	int          slowPhase = 0;
	logic        exp3M;
	logic        exp1M5;

	clockGen u_clockGen (
		.CLK_24M(CLK_24M),
		.T73A_OUT(T73A_OUT)
	);

	lspcCore #(
		.DIV_STAGES(DIV_STAGES_DEF)
	) u_lspcCore (
		.CLK_24M(CLK_24M), .T73A_OUT(T73A_OUT),
		.cpuAddr(cpuAddr), .cpuDataIn(cpuDataIn), .cpuDataOut(cpuDataOut),
		.cpuWe(cpuWe), .cpuRe(cpuRe),
		.vramAddr(vramAddr), .vramWrData(vramWrData), .vramWe(vramWe),
		.vramRdData(vramRdData),
		.frameStrobe(frameStrobe), .sprTile(sprTile), .sprAa2(sprAa2), .sprAa3(sprAa3),
		.sprTileAnim(sprTileAnim), .s1h1(s1h1), .s2h1(s2h1), .aaCount(aaCount)
	);

	// ========================================
	// VRAM model, 64 words, aliased on the low address bits
	// ========================================
	assign vramRdData = vramMem[vramAddr[5:0]];

	always @(posedge CLK_24M)
	begin
		if (!T73A_OUT)
		begin
			// Fill differs for every word, zero at word 0
			for (int i = 0; i < 64; i++)
				vramMem[i] <= 16'(i) * 16'h0B0D;
		end
		else if (vramWe)
		begin
			vramMem[vramAddr[5:0]] <= vramWrData;
		end
	end

	// No write pulse unless a data write is in flight
	always @(negedge CLK_24M)
	begin
		if (!weExpected)
		begin
			assert (vramWe === 1'b0)
			else
			begin
				$display("ERROR t=%0t vramWe expected=0 actual=%b", $time, vramWe);
				strayWeCount++;
			end
		end
	end

	// ========================================
	// Slow clock levels
	// ========================================
	always @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			slowPhase <= 0;
		else
			slowPhase <= slowPhase + 1;
	end

	// 3 MHz level flips every 4 clocks
	// 1.5 MHz level every 8
	always @(negedge CLK_24M)
	begin
		exp3M  = ((slowPhase / 4) % 2) == 1;
		exp1M5 = ((slowPhase / 8) % 2) == 1;
		assert (s1h1 === exp3M)
		else
		begin
			$display("ERROR t=%0t s1h1 expected=%b actual=%b", $time, exp3M, s1h1);
			levelErrCount++;
		end
		assert (s2h1 === exp1M5)
		else
		begin
			$display("ERROR t=%0t s2h1 expected=%b actual=%b", $time, exp1M5, s2h1);
			levelErrCount++;
		end
	end

	// Run limit from the table length
	always @(posedge CLK_24M)
	begin
		cycleCount++;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the stimulus table did not finish", cycleCount);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string opName(input int op);
		case (op)
			OP_WRITE:      return "register write";
			OP_READ:       return "register read";
			OP_VRAM_WRITE: return "VRAM data write";
			OP_VRAM_READ:  return "VRAM read back";
			OP_FRAMES:     return "frame strobes";
			OP_TILE:       return "tile substitution";
			default:       return "idle window";
		endcase
	endfunction

	task automatic addRow(input int op, input logic [2:0] sel,
		input logic [19:0] data, input logic [19:0] exp);
		opTab.push_back(op);
		selTab.push_back(sel);
		dataTab.push_back(data);
		expTab.push_back(exp);
	endtask

	task automatic checkValue(input string sigName, input logic [19:0] exp,
		input logic [19:0] act);
		assert (act === exp)
		else
		begin
			$display("ERROR t=%0t %s expected=%h actual=%h", $time, sigName, exp, act);
			errCount++;
		end
	endtask

	// One-cycle write strobe
	task automatic writeReg(input regSelT sel, input cpuDataT data);
		@(posedge CLK_24M);
		cpuAddr   <= sel;
		cpuDataIn <= data;
		cpuWe     <= 1'b1;
		@(posedge CLK_24M);
		cpuWe <= 1'b0;
	endtask

	// Read strobe, data sampled mid-cycle after the latch edge
	task automatic readReg(input regSelT sel, output cpuDataT data);
		@(posedge CLK_24M);
		cpuAddr <= sel;
		cpuRe   <= 1'b1;
		@(posedge CLK_24M);
		cpuRe <= 1'b0;
		@(negedge CLK_24M);
		data = cpuDataOut;
	endtask

	// Data write, then wait for the slot pulse
	task automatic vramWriteRow(input vramAddrT expAddr);
		cpuDataT wrWord;
		int      waited;
		logic    seen;
		wrWord   = rngState[15:0];
		rngState = xorshift32(rngState);
		@(posedge CLK_24M);
		cpuAddr    <= REG_VRAMRW;
		cpuDataIn  <= wrWord;
		cpuWe      <= 1'b1;
		weExpected = 1'b1;
		@(posedge CLK_24M);
		cpuWe <= 1'b0;
		waited = 0;
		seen   = 1'b0;
		while (!seen && waited < 8)
		begin
			@(negedge CLK_24M);
			waited++;
			seen = vramWe;
		end
		assert (seen)
		else
		begin
			$display("vramWe never pulsed after the data write to address %h", expAddr);
			errCount++;
		end
		if (seen)
		begin
			// First negedge lies in the strobe's own edge cycle
			assert (waited - 1 <= 4)
			else
			begin
				$display("vramWe came %0d cycles after the data write, more than 4", waited - 1);
				errCount++;
			end
			checkValue("vramAddr", {4'h0, expAddr}, {4'h0, vramAddr});
			checkValue("vramWrData", {4'h0, wrWord}, {4'h0, vramWrData});
			@(negedge CLK_24M);
			shadowAddr = expAddr + shadowMod;
			checkValue("vramAddr", {4'h0, shadowAddr}, {4'h0, vramAddr});
			checkValue("vramWe", 20'h0, {19'h0, vramWe});
		end
		weExpected = 1'b0;
	endtask

	task automatic runRow(input int idx);
		cpuDataT got;
		cpuDataT modeExp;
		case (opTab[idx])
			OP_WRITE:
			begin
				writeReg(selTab[idx], dataTab[idx][15:0]);
				if (selTab[idx] == REG_VRAMADDR)
					shadowAddr = dataTab[idx][15:0];
				if (selTab[idx] == REG_VRAMMOD)
					shadowMod = dataTab[idx][15:0];
				if (selTab[idx] == REG_LSPCMODE)
				begin
					shadowSpeed = dataTab[idx][15:8];
					shadowDis   = dataTab[idx][3];
				end
			end
			OP_READ:
			begin
				readReg(selTab[idx], got);
				checkValue("cpuDataOut", expTab[idx], {4'h0, got});
			end
			OP_VRAM_WRITE:
				vramWriteRow(expTab[idx][15:0]);
			OP_VRAM_READ:
			begin
				readReg(REG_VRAMRW, got);
				checkValue("cpuDataOut", {4'h0, vramMem[shadowAddr[5:0]]}, {4'h0, got});
			end
			OP_FRAMES:
			begin
				repeat (dataTab[idx])
				begin
					@(posedge CLK_24M);
					frameStrobe <= 1'b1;
					@(posedge CLK_24M);
					frameStrobe <= 1'b0;
				end
				@(negedge CLK_24M);
				checkValue("aaCount", expTab[idx], {17'h0, aaCount});
				// Same count seen through LSPCMODE
				modeExp = {shadowSpeed, 4'h0, shadowDis, expTab[idx][2:0]};
				readReg(REG_LSPCMODE, got);
				checkValue("cpuDataOut", {4'h0, modeExp}, {4'h0, got});
			end
			OP_TILE:
			begin
				@(posedge CLK_24M);
				sprAa3  <= selTab[idx][1];
				sprAa2  <= selTab[idx][0];
				sprTile <= dataTab[idx];
				@(negedge CLK_24M);
				checkValue("sprTileAnim", expTab[idx], sprTileAnim);
			end
			default:
				repeat (dataTab[idx]) @(negedge CLK_24M);
		endcase
	endtask

	// ========================================
	// Table contents
	// ========================================
	task automatic buildTable();
		// Reset values, and no stray write pulse
		addRow(OP_READ, REG_VRAMADDR, 20'h0, 20'h0);
		addRow(OP_READ, REG_VRAMRW, 20'h0, 20'h0);
		addRow(OP_READ, REG_VRAMMOD, 20'h0, 20'h0);
		addRow(OP_READ, REG_LSPCMODE, 20'h0, 20'h0);
		addRow(OP_IDLE, REG_VRAMADDR, 20'd8, 20'h0);
		// Round trips
		addRow(OP_WRITE, REG_VRAMADDR, 20'h01234, 20'h0);
		addRow(OP_READ, REG_VRAMADDR, 20'h0, 20'h01234);
		addRow(OP_WRITE, REG_VRAMMOD, 20'h000A5, 20'h0);
		addRow(OP_READ, REG_VRAMMOD, 20'h0, 20'h000A5);
		// Modulo 3 stepping, then across the 16-bit wrap
		addRow(OP_WRITE, REG_VRAMMOD, 20'h00003, 20'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 20'h00005, 20'h0);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h00005);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h00008);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h0000B);
		addRow(OP_WRITE, REG_VRAMADDR, 20'h0FFFE, 20'h0);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h0FFFE);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h00001);
		addRow(OP_VRAM_WRITE, REG_VRAMRW, 20'h0, 20'h00004);
		addRow(OP_READ, REG_VRAMADDR, 20'h0, 20'h00007);
		// Read back, written words and one untouched word
		addRow(OP_WRITE, REG_VRAMADDR, 20'h00008, 20'h0);
		addRow(OP_VRAM_READ, REG_VRAMRW, 20'h0, 20'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 20'h0FFFE, 20'h0);
		addRow(OP_VRAM_READ, REG_VRAMRW, 20'h0, 20'h0);
		addRow(OP_WRITE, REG_VRAMADDR, 20'h00020, 20'h0);
		addRow(OP_VRAM_READ, REG_VRAMRW, 20'h0, 20'h0);
		// Speed 2, one step per 3 frames, 13 steps wrap to 5
		addRow(OP_WRITE, REG_LSPCMODE, 20'h00200, 20'h0);
		addRow(OP_FRAMES, REG_LSPCMODE, 20'd3, 20'd1);
		addRow(OP_FRAMES, REG_LSPCMODE, 20'd3, 20'd2);
		addRow(OP_FRAMES, REG_LSPCMODE, 20'd18, 20'd0);
		addRow(OP_FRAMES, REG_LSPCMODE, 20'd15, 20'd5);
		// Tile bits with aaCount at 5, sel bit 1 is aa3 and bit 0 is aa2
		addRow(OP_TILE, 3'b010, 20'hABCDE, 20'hABCDD);
		addRow(OP_TILE, 3'b001, 20'h12347, 20'h12345);
		addRow(OP_TILE, 3'b000, 20'h12347, 20'h12347);
		addRow(OP_WRITE, REG_LSPCMODE, 20'h00208, 20'h0);
		addRow(OP_READ, REG_LSPCMODE, 20'h0, 20'h0020D);
		addRow(OP_TILE, 3'b011, 20'hABCDE, 20'hABCDE);
		addRow(OP_TILE, 3'b001, 20'h12347, 20'h12347);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial
	begin
		int rowStart;
		int failCount;
		int totalErr;
		cpuAddr     = REG_VRAMADDR;
		cpuDataIn   = '0;
		cpuWe       = 1'b0;
		cpuRe       = 1'b0;
		frameStrobe = 1'b0;
		sprTile     = '0;
		sprAa2      = 1'b0;
		sprAa3      = 1'b0;
		weExpected  = 1'b0;
		shadowAddr  = '0;
		shadowMod   = '0;
		shadowSpeed = '0;
		shadowDis   = 1'b0;
		failCount   = 0;
		rngState    = 32'ha9e8;
		buildTable();
		cycleLimit = 20 * opTab.size() + 200;

		wait (T73A_OUT === 1'b1);
		for (int i = 0; i < opTab.size(); i++)
		begin
			rowStart = errCount + strayWeCount + levelErrCount;
			runRow(i);
			if (errCount + strayWeCount + levelErrCount == rowStart)
			begin
				$display("Test %0d (%s) ok", i, opName(opTab[i]));
			end
			else
			begin
				$display("Test %0d (%s) FAILED", i, opName(opTab[i]));
				failCount++;
			end
		end

		totalErr = errCount + strayWeCount + levelErrCount;
		$display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
			opTab.size(), opTab.size() - failCount, failCount, totalErr);
		if (failCount == 0 && totalErr == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/lspcPkg.sv
source/lspcClockDivider.sv
source/lspcCpuRegs.sv
source/vramAddressUnit.sv
source/autoAnimator.sv
source/lspcCore.sv
sim/clockGen.sv
sim/tbLspcCore.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f sim.f --top-module tbLspcCore -o simv \
	> build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1

grep -q "^Simulation passed$" sim.log \
	&& echo "RESULT: PASS" \
	&& exit 0 \
	|| { echo "RESULT: FAIL (see build.log and sim.log)"; exit 1; }
